//--- Makefile
SRCS := $(wildcard design/*.sv design/*.svh testbench/*.sv) sources.f

.PHONY: run clean

obj_dir/Vgb_loader_tb: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module gb_loader_tb -o Vgb_loader_tb

run: obj_dir/Vgb_loader_tb
	./obj_dir/Vgb_loader_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Errors found" sim.log; then echo "FAIL"; exit 1; fi
	@grep -q "No errors" sim.log || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- design/backup_sequencer.sv
// Backup RAM sequencer; host ack must rise after rd or wr and fall once per 512-byte block
`timescale 1ns/100ps
`default_nettype none
`include "gb_loader_consts.svh"

module backup_sequencer (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     cart_download,
	input  logic                     img_mounted,
	input  logic                     img_readonly,
	input  logic                     img_present,
	input  logic                     cart_has_save,
	input  logic [7:0]               ram_mask_file,
	input  gb_loader_pkg::rtc_save_t rtc,
	input  logic                     cram_wr,
	input  logic                     osd_open,
	input  logic                     autosave_en,
	input  logic                     load_req,
	input  logic                     save_req,
	input  logic [15:0]              bk_q,
	input  gb_loader_pkg::sd_buff_t  sd_buff,
	output gb_loader_pkg::sd_req_t   sd_req,
	output logic [15:0]              sd_buff_din,
	output gb_loader_pkg::bk_port_t  bk,
	output logic                     bk_loading,
	output logic                     sav_pending
);

	logic        old_download;
	logic        old_load;
	logic        old_save;
	logic        old_ack;
	logic        bk_ena;
	logic        busy;
	logic [31:0] lba_q;
	logic        rd_q;
	logic        wr_q;
	logic        sav_supported;
	logic        save_level;
	logic        load_edge;
	logic        save_edge;
	logic        dl_start;
	logic        dl_end;
	logic        ack_rise;
	logic        ack_fall;
	logic        rtc_block;
	logic        last_block;
	logic [15:0] rtc_word;

	assign sav_supported = cart_has_save && bk_ena;
	assign save_level    = save_req || (sav_pending && osd_open && autosave_en);

	assign load_edge = load_req && !old_load;
	assign save_edge = save_level && !old_save;
	assign dl_start  = cart_download && !old_download;
	assign dl_end    = !cart_download && old_download;
	assign ack_rise  = sd_buff.ack && !old_ack;
	assign ack_fall  = !sd_buff.ack && old_ack;

	// Blocks past the RAM mask carry the RTC record
	assign rtc_block  = lba_q[7:0] > ram_mask_file;
	assign last_block = rtc.inuse ? rtc_block : (lba_q[7:0] >= ram_mask_file);

	//////////////////////////////
	// Save enable and autosave
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			bk_ena       <= 1'b0;
			sav_pending  <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (dl_start) begin
				bk_ena <= 1'b0;
			end
			// The host mounts the save file while the ROM is still loading
			if (cart_download && img_mounted && !img_readonly) begin
				bk_ena <= 1'b1;
			end
			if (cram_wr && !osd_open && sav_supported) begin
				sav_pending <= 1'b1;
			end else if (busy) begin
				sav_pending <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// Block sequencer
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			busy       <= 1'b0;
			bk_loading <= 1'b0;
			lba_q      <= 32'd0;
			rd_q       <= 1'b0;
			wr_q       <= 1'b0;
		end else begin
			old_load <= load_req;
			old_save <= save_level;
			old_ack  <= sd_buff.ack;

			// Host has taken the request
			if (ack_rise) begin
				rd_q <= 1'b0;
				wr_q <= 1'b0;
			end

			if (!busy) begin
				if (bk_ena && (load_edge || save_edge)) begin
					busy       <= 1'b1;
					bk_loading <= load_edge;
					lba_q      <= 32'd0;
					rd_q       <= load_edge;
					wr_q       <= !load_edge;
				end
				// Fresh cartridge, pull its save in
				if (dl_end && img_present && bk_ena) begin
					busy       <= 1'b1;
					bk_loading <= 1'b1;
					lba_q      <= 32'd0;
					rd_q       <= 1'b1;
					wr_q       <= 1'b0;
				end
			end else if (ack_fall) begin
				if (last_block) begin
					busy       <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					lba_q <= lba_q + 32'd1;
					rd_q  <= bk_loading;
					wr_q  <= !bk_loading;
				end
			end
		end
	end

	assign sd_req.lba = lba_q;
	assign sd_req.rd  = rd_q;
	assign sd_req.wr  = wr_q;

	//////////////////////////////
	// Buffer routing
	//////////////////////////////

	assign bk.addr   = {1'b0, lba_q[7:0], sd_buff.addr};
	assign bk.data   = sd_buff.dout;
	assign bk.wr     = !rtc_block && sd_buff.wr && sd_buff.ack;
	assign bk.rtc_wr = rtc_block && sd_buff.wr && sd_buff.ack;

	// Low half first, timestamp then saved time
	always_comb begin
		case (sd_buff.addr[1:0])
			2'd0:    rtc_word = rtc.timestamp[15:0];
			2'd1:    rtc_word = rtc.timestamp[31:16];
			2'd2:    rtc_word = rtc.savedtime[15:0];
			default: rtc_word = rtc.savedtime[31:16];
		endcase
	end

	assign sd_buff_din = !rtc_block ? bk_q :
		(sd_buff.addr < `GB_RTC_WORDS) ? rtc_word : `GB_BUFF_FILL;

endmodule

`default_nettype wire

//--- design/download_unit.sv
// Download decoder; ioctl wr is a one-cycle strobe, cheat words must arrive in 16-byte groups
`timescale 1ns/100ps
`default_nettype none
`include "gb_loader_consts.svh"

module download_unit (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  gb_loader_pkg::ioctl_t      ioctl,
	output logic                       cart_download,
	output logic                       rom_wr,
	output logic [23:0]                rom_wr_addr,
	output logic [15:0]                rom_wr_data,
	output gb_loader_pkg::palette_t    palette,
	output gb_loader_pkg::cheat_code_t cheat
);

	logic                       rom_type;
	logic                       palette_download;
	logic                       code_download;
	logic [127:0]               palette_q;
	gb_loader_pkg::cheat_code_t cheat_q;

	//////////////////////////////
	// File type decode
	//////////////////////////////

	assign rom_type = (ioctl.index == `GB_FT_ROM_GB) ||
		(ioctl.index == `GB_FT_ROM_GBC) ||
		(ioctl.index == `GB_FT_ROM_SGB);

	assign cart_download    = ioctl.download && rom_type;
	assign palette_download = ioctl.download && (ioctl.index == `GB_FT_PALETTE);
	assign code_download    = ioctl.download && (ioctl.index == `GB_FT_CHEAT);

	// ROM image goes to the word-addressed memory
	assign rom_wr      = cart_download && ioctl.wr;
	assign rom_wr_addr = ioctl.addr[24:1];
	assign rom_wr_data = ioctl.dout;

	//////////////////////////////
	// Palette register
	//////////////////////////////

	// Host words are little endian, the palette is stored big endian
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			palette_q <= `GB_PALETTE_DEFAULT;
		end else if (palette_download && ioctl.wr) begin
			palette_q <= {palette_q[111:0], ioctl.dout[7:0], ioctl.dout[15:8]};
		end
	end

	// Low 32 bits are shifted through but not used
	assign palette = gb_loader_pkg::palette_t'(palette_q[127:32]);

	//////////////////////////////
	// Cheat code assembly
	//////////////////////////////

	// Bottom word of each field comes first
	always_ff @(posedge clk_sys) begin
		if (code_download && ioctl.wr) begin
			case (ioctl.addr[3:0])
				4'd0:  cheat_q.flags[15:0]    <= ioctl.dout;
				4'd2:  cheat_q.flags[31:16]   <= ioctl.dout;
				4'd4:  cheat_q.address[15:0]  <= ioctl.dout;
				4'd6:  cheat_q.address[31:16] <= ioctl.dout;
				4'd8:  cheat_q.compare[15:0]  <= ioctl.dout;
				4'd10: cheat_q.compare[31:16] <= ioctl.dout;
				4'd12: cheat_q.replace[15:0]  <= ioctl.dout;
				4'd14: cheat_q.replace[31:16] <= ioctl.dout;
				default: ;
			endcase
		end
	end

	// One-cycle strobe once the top replace word is in
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_q.strobe <= 1'b0;
		end else begin
			cheat_q.strobe <= code_download && ioctl.wr && (ioctl.addr[3:0] == 4'd14);
		end
	end

	assign cheat = cheat_q;

endmodule

`default_nettype wire

//--- design/gb_loader_consts.svh
// Loader constants; file-type codes must match the host menu, RTC block holds only 4 words
`ifndef GB_LOADER_CONSTS_SVH
`define GB_LOADER_CONSTS_SVH

//////////////////////////////
// Download file types
//////////////////////////////

// Cartridge ROM images, plain, color and super variants
`define GB_FT_ROM_GB        8'h01
`define GB_FT_ROM_GBC       8'h41
`define GB_FT_ROM_SGB       8'h80

// Custom palette file
`define GB_FT_PALETTE       8'h03

// Cheat codes use the all-ones index
`define GB_FT_CHEAT         8'hFF

//////////////////////////////
// Register defaults
//////////////////////////////

// Four 24-bit palettes in the top 96 bits, low word unused
`define GB_PALETTE_DEFAULT  128'h828214517356305A5F1A3B4900000000

// Returned for RTC block words past the meaningful ones
`define GB_BUFF_FILL        16'hFFFF

// Timestamp and saved time, two 16-bit halves each
// Sized to the host buffer address
`define GB_RTC_WORDS        8'd4

`endif

//--- design/gb_loader_pkg.sv
// Bus and record types for the loader; widths follow the 16-bit wide host interface
`default_nettype none

package gb_loader_pkg;

	//////////////////////////////
	// Host side
	//////////////////////////////

	// Download stream, one word per wr strobe
	typedef struct packed {
		logic        download;
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [15:0] dout;
	} ioctl_t;

	// Block request, rd and wr are levels held until ack rises
	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	// Buffer side of the block transfer
	typedef struct packed {
		logic        ack;
		logic [7:0]  addr;
		logic [15:0] dout;
		logic        wr;
	} sd_buff_t;

	//////////////////////////////
	// Console side
	//////////////////////////////

	// pal1 is the topmost 24 bits of the palette register
	typedef struct packed {
		logic [23:0] pal1;
		logic [23:0] pal2;
		logic [23:0] pal3;
		logic [23:0] pal4;
	} palette_t;

	// Strobe pulses once per complete code
	typedef struct packed {
		logic        strobe;
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic [15:0] addr;
		logic        rd;
		logic        cram_rd;
		logic [9:0]  mbc_bank;
	} cart_req_t;

	// Word-wide ROM memory port, ds is the byte lane enable
	typedef struct packed {
		logic [23:0] addr;
		logic [15:0] din;
		logic [1:0]  ds;
		logic        we;
		logic        oe;
	} rom_port_t;

	typedef struct packed {
		logic [16:0] addr;
		logic [15:0] data;
		logic        wr;
		logic        rtc_wr;
	} bk_port_t;

	typedef struct packed {
		logic [31:0] timestamp;
		logic [31:0] savedtime;
		logic        inuse;
	} rtc_save_t;

endpackage

`default_nettype wire

//--- design/gb_loader_top.sv
// Loader top level; single clock domain, all host signals assumed synchronous to clk_sys
`timescale 1ns/100ps
`default_nettype none

module gb_loader_top (
	input  logic                       clk_sys,
	input  logic                       reset,

	// Host download and block interface
	input  gb_loader_pkg::ioctl_t      ioctl,
	input  gb_loader_pkg::sd_buff_t    sd_buff,
	output gb_loader_pkg::sd_req_t     sd_req,
	output logic [15:0]                sd_buff_din,
	input  logic                       img_mounted,
	input  logic                       img_readonly,
	input  logic                       img_present,

	// Cartridge and ROM memory
	input  gb_loader_pkg::cart_req_t   cart,
	input  logic [15:0]                rom_rdata,
	output gb_loader_pkg::rom_port_t   rom_port,
	output logic [7:0]                 cart_do,

	// Backup RAM
	input  logic                       cart_has_save,
	input  logic [7:0]                 ram_mask_file,
	input  gb_loader_pkg::rtc_save_t   rtc,
	input  logic                       cram_wr,
	input  logic [15:0]                bk_q,
	output gb_loader_pkg::bk_port_t    bk,
	output logic                       bk_loading,
	output logic                       sav_pending,

	// User controls
	input  logic                       osd_open,
	input  logic                       autosave_en,
	input  logic                       load_req,
	input  logic                       save_req,

	output gb_loader_pkg::palette_t    palette,
	output gb_loader_pkg::cheat_code_t cheat
);

	logic        cart_download;
	logic        rom_wr;
	logic [23:0] rom_wr_addr;
	logic [15:0] rom_wr_data;

	download_unit u_download (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.ioctl         (ioctl),
		.cart_download (cart_download),
		.rom_wr        (rom_wr),
		.rom_wr_addr   (rom_wr_addr),
		.rom_wr_data   (rom_wr_data),
		.palette       (palette),
		.cheat         (cheat)
	);

	rom_port_arbiter u_arbiter (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.rom_wr        (rom_wr),
		.rom_wr_addr   (rom_wr_addr),
		.rom_wr_data   (rom_wr_data),
		.cart          (cart),
		.rom_rdata     (rom_rdata),
		.rom_port      (rom_port),
		.cart_do       (cart_do)
	);

	backup_sequencer u_backup (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_present   (img_present),
		.cart_has_save (cart_has_save),
		.ram_mask_file (ram_mask_file),
		.rtc           (rtc),
		.cram_wr       (cram_wr),
		.osd_open      (osd_open),
		.autosave_en   (autosave_en),
		.load_req      (load_req),
		.save_req      (save_req),
		.bk_q          (bk_q),
		.sd_buff       (sd_buff),
		.sd_req        (sd_req),
		.sd_buff_din   (sd_buff_din),
		.bk            (bk),
		.bk_loading    (bk_loading),
		.sav_pending   (sav_pending)
	);

endmodule

`default_nettype wire

//--- design/rom_port_arbiter.sv
// ROM port arbiter; download always wins, port and read byte lag the request by one cycle
`timescale 1ns/100ps
`default_nettype none

module rom_port_arbiter (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     cart_download,
	input  logic                     rom_wr,
	input  logic [23:0]              rom_wr_addr,
	input  logic [15:0]              rom_wr_data,
	input  gb_loader_pkg::cart_req_t cart,
	input  logic [15:0]              rom_rdata,
	output gb_loader_pkg::rom_port_t rom_port,
	output logic [7:0]               cart_do
);

	gb_loader_pkg::rom_port_t port_q;
	logic                     lane_hi;

	//////////////////////////////
	// Port control
	//////////////////////////////

	// Reads are held off for the whole download
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port_q.we <= 1'b0;
			port_q.oe <= 1'b0;
		end else begin
			port_q.we <= cart_download && rom_wr;
			port_q.oe <= !cart_download && cart.rd && !cart.cram_rd;
		end
	end

	//////////////////////////////
	// Port payload
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (cart_download) begin
			port_q.addr <= rom_wr_addr;
			port_q.din  <= rom_wr_data;
			port_q.ds   <= 2'b11;
		end else begin
			// Banked word address, 8 KB window per bank
			port_q.addr <= {2'b00, cart.mbc_bank, cart.addr[12:1]};
			port_q.din  <= 16'd0;
			port_q.ds   <= {cart.addr[0], ~cart.addr[0]};
		end
		lane_hi <= cart.addr[0];
	end

	assign rom_port = port_q;

	// Odd addresses live in the high byte
	assign cart_do = lane_hi ? rom_rdata[15:8] : rom_rdata[7:0];

endmodule

`default_nettype wire

//--- sources.f
+incdir+design
design/gb_loader_pkg.sv
design/download_unit.sv
design/rom_port_arbiter.sv
design/backup_sequencer.sv
design/gb_loader_top.sv
testbench/gb_loader_checker.sv
testbench/gb_loader_tb.sv

//--- testbench/gb_loader_checker.sv
// Protocol checks on the loader top level; sampled on clk_sys, idle while reset is high
`timescale 1ns/100ps
`default_nettype none

module gb_loader_checker (
	input logic                     clk_sys,
	input logic                     reset,
	input logic                     cart_download,
	input gb_loader_pkg::sd_req_t   sd_req,
	input gb_loader_pkg::bk_port_t  bk,
	input gb_loader_pkg::rom_port_t rom_port
);

	//////////////////////////////
	// Host block interface
	//////////////////////////////

	a_req_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_req.rd && sd_req.wr))
		else $error("Block read and write requested together");

	a_bk_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(bk.wr && bk.rtc_wr))
		else $error("Backup RAM and RTC written in the same cycle");

	//////////////////////////////
	// ROM port
	//////////////////////////////

	// Port is registered, so the write follows the download by one cycle
	a_we_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		rom_port.we |-> $past(cart_download))
		else $error("ROM port written outside a cartridge download");

endmodule

`default_nettype wire

//--- testbench/gb_loader_tb.sv
// Loader testbench; RAM mask fixed at 1 so each backup sequence is three 256-word blocks
`timescale 1ns/100ps
`default_nettype none
`include "gb_loader_consts.svh"

module gb_loader_tb;

	localparam int SEQ_CYCLES = 3 * (256 + 12) + 20;
	localparam int RUN_CYCLES = 3 * SEQ_CYCLES + 600;

	logic                       clk_sys;
	logic                       reset;
	gb_loader_pkg::ioctl_t      ioctl;
	gb_loader_pkg::sd_buff_t    sd_buff;
	gb_loader_pkg::sd_req_t     sd_req;
	logic [15:0]                sd_buff_din;
	logic                       img_mounted;
	logic                       img_readonly;
	logic                       img_present;
	gb_loader_pkg::cart_req_t   cart;
	logic [15:0]                rom_rdata;
	gb_loader_pkg::rom_port_t   rom_port;
	logic [7:0]                 cart_do;
	logic                       cart_has_save;
	logic [7:0]                 ram_mask_file;
	gb_loader_pkg::rtc_save_t   rtc;
	logic                       cram_wr;
	logic [15:0]                bk_q;
	gb_loader_pkg::bk_port_t    bk;
	logic                       bk_loading;
	logic                       sav_pending;
	logic                       osd_open;
	logic                       autosave_en;
	logic                       load_req;
	logic                       save_req;
	gb_loader_pkg::palette_t    palette;
	gb_loader_pkg::cheat_code_t cheat;

	logic [15:0] rom_mem [0:1023];
	logic [15:0] rom_words [0:15];
	logic [15:0] save_img [0:3][0:255];
	logic [32:0] bk_log [$];
	logic [15:0] img_seed;
	int          rtc_count;
	int          strobe_count;
	int          wr_blocks;
	int          checks;
	int          errors;
	logic        host_rd;
	logic [31:0] host_lba;

	gb_loader_top u_gb_loader_top (.*);

	bind gb_loader_top gb_loader_checker u_checker (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.sd_req        (sd_req),
		.bk            (bk),
		.rom_port      (rom_port)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	//////////////////////////////
	// Memory and host models
	//////////////////////////////

	assign rom_rdata = rom_mem[rom_port.addr[9:0]];
	assign bk_q      = bk.addr[15:0] ^ {15'h0, bk.addr[16]} ^ 16'hA5C3;

	always @(posedge clk_sys) begin
		if (rom_port.we) begin
			rom_mem[rom_port.addr[9:0]] <= rom_port.din;
		end
	end

	function automatic logic [15:0] img_word(input logic [31:0] lba, input int a);
		return img_seed ^ {lba[7:0], a[7:0]};
	endfunction

	// Cartridge RAM word for a backup address
	function automatic logic [15:0] ram_word(input logic [16:0] addr);
		return addr[15:0] ^ {15'h0, addr[16]} ^ 16'hA5C3;
	endfunction

	// Host answers each block request after a random delay
	initial begin
		forever begin
			@(posedge clk_sys);
			if (sd_req.rd || sd_req.wr) begin
				host_rd  = sd_req.rd;
				host_lba = sd_req.lba;
				if (!host_rd) begin
					wr_blocks++;
				end
				repeat ($urandom_range(1, 4)) @(posedge clk_sys);
				sd_buff.ack <= 1'b1;
				for (int a = 0; a < 256; a++) begin
					@(posedge clk_sys);
					sd_buff.addr <= a[7:0];
					sd_buff.wr   <= host_rd;
					sd_buff.dout <= img_word(host_lba, a);
					@(negedge clk_sys);
					if (!host_rd) begin
						save_img[host_lba[1:0]][a] = sd_buff_din;
					end
				end
				@(posedge clk_sys);
				sd_buff.wr  <= 1'b0;
				sd_buff.ack <= 1'b0;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (bk.wr) begin
			bk_log.push_back({bk.addr, bk.data});
		end
		if (bk.rtc_wr) begin
			rtc_count++;
		end
		if (cheat.strobe) begin
			strobe_count++;
		end
	end

	//////////////////////////////
	// Helper tasks
	//////////////////////////////

	task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
		checks++;
		assert (exp === act)
		else begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic start_download(input logic [7:0] index);
		@(posedge clk_sys);
		ioctl.download <= 1'b1;
		ioctl.index    <= index;
	endtask

	task automatic send_word(input int addr, input logic [15:0] data);
		@(posedge clk_sys);
		ioctl.wr   <= 1'b1;
		ioctl.addr <= addr[24:0];
		ioctl.dout <= data;
		@(posedge clk_sys);
		ioctl.wr <= 1'b0;
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		ioctl.download <= 1'b0;
	endtask

	// Waits for the backup FSM to start and then to go idle
	task automatic wait_sequence(input string name);
		int n;
		n = 0;
		while (!u_gb_loader_top.u_backup.busy && n < 100) begin
			@(negedge clk_sys);
			n++;
		end
		if (!u_gb_loader_top.u_backup.busy) begin
			$display("%s: backup sequence never started", name);
			errors++;
		end else begin
			n = 0;
			while (u_gb_loader_top.u_backup.busy && n < SEQ_CYCLES) begin
				@(negedge clk_sys);
				n++;
			end
			if (u_gb_loader_top.u_backup.busy) begin
				$display("%s: backup sequence did not finish in time", name);
				errors++;
			end
		end
	endtask

	task automatic report(input string name);
		$display("Test %s finished, %0d errors so far", name, errors);
	endtask

	//////////////////////////////
	// Watchdog
	//////////////////////////////

	initial begin
		repeat (2 * RUN_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired before the tests completed");
		$display("Errors found");
		$finish;
	end

	//////////////////////////////
	// Tests
	//////////////////////////////

	initial begin
		logic [127:0] pal_model;
		logic [15:0]  w [0:7];
		logic [16:0]  exp_addr;
		logic [15:0]  exp_data;
		logic [9:0]   bank;
		int           a;
		void'($urandom(34819));
		checks = 0;
		errors = 0;
		rtc_count = 0;
		strobe_count = 0;
		wr_blocks = 0;
		reset = 1'b1;
		ioctl = '0;
		sd_buff = '0;
		cart = '0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_present = 1'b0;
		cart_has_save = 1'b1;
		ram_mask_file = 8'd1;
		rtc = '0;
		cram_wr = 1'b0;
		osd_open = 1'b0;
		autosave_en = 1'b0;
		load_req = 1'b0;
		save_req = 1'b0;
		img_seed = 16'h0;
		for (int i = 0; i < 1024; i++) begin
			rom_mem[i] = i[15:0] ^ 16'hC3A5;
		end
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;

		// Palette default and byte-swapped shifts
		@(negedge clk_sys);
		pal_model = `GB_PALETTE_DEFAULT;
		check("palette_reset", {32'h0, pal_model[127:32]}, {32'h0, palette});
		start_download(`GB_FT_PALETTE);
		for (int i = 0; i < 10; i++) begin
			w[0] = $urandom;
			send_word(2 * i, w[0]);
			pal_model = {pal_model[111:0], w[0][7:0], w[0][15:8]};
		end
		end_download();
		@(negedge clk_sys);
		check("palette_shift", {32'h0, pal_model[127:32]}, {32'h0, palette});
		report("palette");

		// Cheat code from eight words
		strobe_count = 0;
		start_download(`GB_FT_CHEAT);
		for (int i = 0; i < 8; i++) begin
			w[i] = $urandom;
			send_word(2 * i, w[i]);
		end
		end_download();
		repeat (3) @(negedge clk_sys);
		check("cheat_flags", {w[1], w[0]}, cheat.flags);
		check("cheat_address", {w[3], w[2]}, cheat.address);
		check("cheat_compare", {w[5], w[4]}, cheat.compare);
		check("cheat_replace", {w[7], w[6]}, cheat.replace);
		check("cheat_strobe_count", 1, strobe_count);
		report("cheat");

		// ROM download with a mounted writable image and cartridge reads
		img_mounted <= 1'b1;
		start_download(`GB_FT_ROM_GB);
		for (int i = 0; i < 16; i++) begin
			rom_words[i] = $urandom;
			send_word(2 * i, rom_words[i]);
		end
		// Reads are not served while the download holds the port
		@(posedge clk_sys);
		cart.rd <= 1'b1;
		@(posedge clk_sys);
		cart.rd <= 1'b0;
		@(negedge clk_sys);
		check("cart_read_blocked", 0, rom_port.oe);
		end_download();
		repeat (3) @(negedge clk_sys);
		for (int i = 0; i < 16; i++) begin
			check("rom_write", rom_words[i], rom_mem[i]);
		end
		for (int i = 0; i < 8; i++) begin
			a = $urandom_range(0, 31);
			bank = $urandom;
			@(posedge clk_sys);
			cart.addr     <= a[15:0];
			cart.mbc_bank <= bank;
			cart.rd       <= 1'b1;
			@(posedge clk_sys);
			cart.rd <= 1'b0;
			@(negedge clk_sys);
			exp_data = rom_words[a / 2];
			check("cart_read", a[0] ? exp_data[15:8] : exp_data[7:0], cart_do);
			check("cart_read_oe", 1, rom_port.oe);
			check("cart_read_ds", {a[0], !a[0]}, rom_port.ds);
			check("cart_read_addr", {2'b00, bank, a[12:1]}, rom_port.addr);
		end
		report("rom");

		// Load triggered by the end of a download with an image present
		img_seed = $urandom;
		rtc.timestamp <= $urandom;
		rtc.savedtime <= $urandom;
		rtc.inuse     <= 1'b1;
		img_present   <= 1'b1;
		bk_log.delete();
		rtc_count = 0;
		start_download(`GB_FT_ROM_GBC);
		send_word(0, rom_words[0]);
		end_download();
		wait_sequence("load");
		check("load_word_count", 512, bk_log.size());
		for (int i = 0; i < bk_log.size() && i < 512; i++) begin
			exp_addr = {1'b0, i[15:8], i[7:0]};
			exp_data = img_word(i / 256, i % 256);
			check("load_word", {exp_addr, exp_data}, bk_log[i]);
		end
		check("load_rtc_count", 256, rtc_count);
		check("load_bk_loading", 0, bk_loading);
		report("load");

		// Save on request
		@(posedge clk_sys);
		save_req <= 1'b1;
		@(posedge clk_sys);
		save_req <= 1'b0;
		wait_sequence("save");
		for (int b = 0; b < 3; b++) begin
			for (int i = 0; i < 256; i++) begin
				if (b < 2) begin
					exp_data = ram_word({1'b0, b[7:0], i[7:0]});
				end else if (i < 4) begin
					exp_data = (i == 0) ? rtc.timestamp[15:0] :
						(i == 1) ? rtc.timestamp[31:16] :
						(i == 2) ? rtc.savedtime[15:0] : rtc.savedtime[31:16];
				end else begin
					exp_data = `GB_BUFF_FILL;
				end
				check("save_word", exp_data, save_img[b][i]);
			end
		end
		report("save");

		// Autosave after a cartridge RAM write
		wr_blocks = 0;
		@(posedge clk_sys);
		cram_wr <= 1'b1;
		@(posedge clk_sys);
		cram_wr <= 1'b0;
		@(negedge clk_sys);
		check("autosave_pending_set", 1, sav_pending);
		@(posedge clk_sys);
		osd_open    <= 1'b1;
		autosave_en <= 1'b1;
		wait_sequence("autosave");
		check("autosave_pending_clear", 0, sav_pending);
		check("autosave_blocks", 3, wr_blocks);
		osd_open <= 1'b0;
		report("autosave");

		$display("Tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
